//--- compile.f
hw/ctrl_pkg.sv
hw/spi_register_set.sv
hw/spi_port_mux.sv
hw/out_mode_select.sv
hw/fpga_ctrl_top.sv
test/tb_clock.sv
test/fpga_ctrl_props.sv
test/tb_fpga_ctrl.sv

//--- Makefile
# verilator build and run of the spi control plane testbench

VERILATOR ?= verilator
TOP       ?= tb_fpga_ctrl
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "no pass report in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_fpga_ctrl.sv
/*
 * testbench for the spi control plane
 * spi frames against a reference register image, led modes,
 * pass-through routing, watchdog and final report
 */

module tb_fpga_ctrl;

  import ctrl_pkg::*;

  localparam logic [1:0] cs_pol       = 2'b01;     // 4094 strobe active high
  localparam reg_addr_t  addr_unknown = 7'h55;
  localparam int n_rounds    = 3;
  localparam int n_status    = 4;
  localparam int pattern_len = 40;                 // cycles watched in pattern mode
  localparam int mux_cycles  = 16;
  // reset reads, rounds, status, modes, mux setup
  localparam int n_frames  = 7 + n_rounds * 13 + n_status * 2 + 10 + 2;
  localparam int wd_cycles = n_frames * 50 + 1000;

  logic       sck;
  logic       rst_n;
  logic       ss;
  logic       spi_cs2;
  logic       sdi;
  logic       sdo;
  led_vec_t   leds;
  hw_flags_t  hw_flags;
  logic       oe_4094;
  logic [1:0] port_cs;
  logic [1:0] port_clk;
  logic [1:0] port_mosi;
  logic [1:0] port_miso;

  reg_word_t   ref_img [128];   // register image by address
  string       name_q [$];      // pending checks
  logic [31:0] act_q [$];
  logic [31:0] exp_q [$];
  event        chk_ev;
  bit          finished_ok;
  bit          fail_seen;

  tb_clock i_clock (
    .clk   (sck),
    .rst_n (rst_n)
  );

  fpga_ctrl_top #(
    .num_spi_ports (2),
    .cs_polarity   (cs_pol),
    .pattern_shift (3)
  ) i_dut (
    .sck       (sck),
    .rst_n     (rst_n),
    .ss        (ss),
    .spi_cs2   (spi_cs2),
    .sdi       (sdi),
    .sdo       (sdo),
    .leds      (leds),
    .hw_flags  (hw_flags),
    .oe_4094   (oe_4094),
    .port_cs   (port_cs),
    .port_clk  (port_clk),
    .port_mosi (port_mosi),
    .port_miso (port_miso)
  );

  bind fpga_ctrl_top fpga_ctrl_props #(
    .num_spi_ports (num_spi_ports),
    .cs_polarity   (cs_polarity)
  ) i_props (
    .sck     (sck),
    .rst_n   (rst_n),
    .ss      (ss),
    .spi_cs2 (spi_cs2),
    .sdo     (sdo),
    .oe_4094 (oe_4094),
    .port_cs (port_cs)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  // read value as it stands before a frame
  function automatic reg_word_t read_image(input reg_addr_t addr, input hw_flags_t flags);
    if (addr <= addr_direct) begin
      return ref_img[addr];
    end else if (addr == addr_status) begin
      return {28'd0, ref_img[addr_4094][0], flags};   // oe above the flags
    end
    return '0;
  endfunction

  function automatic void write_image(input reg_addr_t addr, input reg_word_t data);
    if (addr <= addr_direct) begin
      ref_img[addr] = data;   // status and unknown dropped
    end
  endfunction

  function automatic led_vec_t leds_for_mode();
    case (ref_img[addr_mode][2:0])
      mode_led:    return ref_img[addr_led][3:0];
      mode_all_on: return 4'hf;
      mode_direct: return ref_img[addr_direct][3:0];
      default:     return 4'h0;   // pattern handled apart
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checking

  task automatic report_failure(input string why);
    $display("%s", why);
    fail_seen = 1'b1;
    $display("TEST FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("Error at %0t: %s is %h, expected %h", $time, name, act, exp));
    end
  endtask

  task automatic expect_value(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
    name_q.push_back(name);
    act_q.push_back(act);
    exp_q.push_back(exp);
    -> chk_ev;
  endtask

  // compare process drains whatever the stimulus queued
  always begin
    @(chk_ev);
    while (act_q.size() > 0) begin
      check_value(name_q.pop_front(), act_q.pop_front(), exp_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // spi master

  // runs from rising edge + 1 to rising edge + 1
  task automatic spi_xfer(input logic [frame_bits-1:0] frame, output reg_word_t rd);
    logic [frame_bits-1:0] sh;
    sh = frame;
    rd = '0;
    for (int i = 0; i < frame_bits; i++) begin
      if (i >= 8) begin
        rd = {rd[30:0], sdo};   // bit shown after the previous edge
      end
      ss  = 1'b0;
      sdi = sh[frame_bits-1];   // msb first
      sh  = sh << 1;
      @(posedge sck);
      #1;
    end
    ss  = 1'b1;
    sdi = 1'b0;
    @(posedge sck);   // one idle cycle between frames
    #1;
  endtask

  task automatic xfer_check(input logic wr, input reg_addr_t addr, input reg_word_t data);
    reg_word_t exp_rd;
    reg_word_t got;
    exp_rd = read_image(addr, hw_flags);
    spi_xfer({wr, addr, data}, got);
    expect_value($sformatf("sdo word of addr %0d", addr), got, exp_rd);
    if (wr) begin
      write_image(addr, data);
    end
  endtask

  // sel is the one hot port that should carry the bus or 0 when idle
  task automatic compare_port_lines(input logic [1:0] sel, input logic sck_lvl);
    logic [1:0] exp_cs;
    logic [1:0] exp_clk;
    logic [1:0] exp_mosi;
    logic       exp_sdo;
    exp_cs   = ~(sel ^ cs_pol);
    exp_clk  = sck_lvl ? sel : 2'b00;
    exp_mosi = sdi ? sel : 2'b00;
    exp_sdo  = 1'b0;
    for (int i = 0; i < 2; i++) begin
      if (sel[i]) begin
        exp_sdo = port_miso[i];   // miso of the routed port
      end
    end
    expect_value("port_cs", 32'(port_cs), 32'(exp_cs));
    expect_value("port_clk", 32'(port_clk), 32'(exp_clk));
    expect_value("port_mosi", 32'(port_mosi), 32'(exp_mosi));
    expect_value("sdo", 32'(sdo), 32'(exp_sdo));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    ss        = 1'b1;
    spi_cs2   = 1'b1;
    sdi       = 1'b0;
    hw_flags  = '0;
    port_miso = '0;
    void'($urandom(32'hebde));
    foreach (ref_img[i]) begin
      ref_img[i] = '0;
    end

    wait (rst_n === 1'b1);
    @(posedge sck);
    #1;

    // reset state
    expect_value("leds", 32'(leds), 32'h0);
    expect_value("oe_4094", 32'(oe_4094), 32'h0);
    for (int a = 0; a <= 5; a++) begin
      xfer_check(1'b0, reg_addr_t'(a), '0);
    end
    xfer_check(1'b0, addr_unknown, '0);

    // random writes with the old value coming back each frame
    for (int r = 0; r < n_rounds; r++) begin
      hw_flags = hw_flags_t'($urandom);
      for (int a = 0; a <= 4; a++) begin
        xfer_check(1'b1, reg_addr_t'(a), reg_word_t'($urandom));
      end
      xfer_check(1'b1, addr_status, reg_word_t'($urandom));   // read only
      xfer_check(1'b1, addr_unknown, reg_word_t'($urandom));
      for (int a = 0; a <= 5; a++) begin
        xfer_check(1'b0, reg_addr_t'(a), reg_word_t'($urandom));   // no wr flag
      end
    end

    // status follows flags and oe
    for (int s = 0; s < n_status; s++) begin
      hw_flags = hw_flags_t'($urandom);
      xfer_check(1'b1, addr_4094, reg_word_t'($urandom));
      expect_value("oe_4094", 32'(oe_4094), 32'(ref_img[addr_4094][0]));
      xfer_check(1'b0, addr_status, '0);
    end

    // led modes with random upper mode bits
    xfer_check(1'b1, addr_led, reg_word_t'($urandom));
    xfer_check(1'b1, addr_direct, reg_word_t'($urandom));
    for (int code = 0; code < 8; code++) begin
      xfer_check(1'b1, addr_mode, (reg_word_t'($urandom) & ~32'h7) | reg_word_t'(code));
      repeat (3) @(posedge sck);
      #1;
      if (mode_t'(code) == mode_pattern) begin
        for (int c = 0; c < pattern_len; c++) begin
          expect_value("leds one hot count", 32'($countones(leds)), 32'd1);
          @(posedge sck);
          #1;
        end
      end else begin
        expect_value("leds", 32'(leds), 32'(leds_for_mode()));
      end
    end

    // pass-through to the port picked by the lowest set bit
    for (int p = 0; p < 2; p++) begin
      xfer_check(1'b1, addr_spi_mux, (reg_word_t'($urandom) << (p + 1)) | (32'd1 << p));
      spi_cs2 = 1'b0;
      repeat (mux_cycles) begin
        sdi       = 1'($urandom);
        port_miso = 2'($urandom);
        @(negedge sck);
        #1;
        compare_port_lines(2'b01 << p, 1'b0);
        @(posedge sck);
        #1;
        compare_port_lines(2'b01 << p, 1'b1);
      end
      spi_cs2   = 1'b1;
      sdi       = 1'b0;
      port_miso = '0;
      @(posedge sck);
      #1;
      compare_port_lines(2'b00, 1'b1);   // both ports idle again
    end

    @(posedge sck);
    #1;
    if (act_q.size() == 0) begin
      finished_ok = 1'b1;
      $display("TEST PASS");
      $finish;
    end else begin
      report_failure($sformatf("%0d checks were never compared", act_q.size()));
    end
  end

  // watchdog
  initial begin
    repeat (wd_cycles) @(posedge sck);
    report_failure($sformatf("timeout, sequence not done after %0d cycles", wd_cycles));
  end

  // run stopped elsewhere such as by an assertion
  final begin
    if (!finished_ok && !fail_seen) begin
      $display("run ended before the test sequence completed");
      $display("TEST FAIL");
    end
  end

endmodule

//--- test/fpga_ctrl_props.sv
/*
 * control plane properties
 * 4094 enable held off in reset, one external select at a time,
 * sdo quiet while neither select is active
 */

module fpga_ctrl_props #(
  parameter int                       num_spi_ports = 2,
  parameter logic [num_spi_ports-1:0] cs_polarity   = num_spi_ports'(1)
) (
  input logic                     sck,
  input logic                     rst_n,
  input logic                     ss,
  input logic                     spi_cs2,
  input logic                     sdo,
  input logic                     oe_4094,
  input logic [num_spi_ports-1:0] port_cs
);

  logic [num_spi_ports-1:0] cs_active;

  assign cs_active = ~(port_cs ^ cs_polarity);   // 1 where the select is asserted

  a_oe_in_reset: assert property (@(posedge sck) !rst_n |-> !oe_4094)
    else $error("oe_4094 high while rst_n is low");

  a_one_select: assert property (@(posedge sck) disable iff (!rst_n) $onehot0(cs_active))
    else $error("more than one port select asserted: %b", port_cs);

  a_idle_sdo: assert property (@(posedge sck) disable iff (!rst_n) (ss && spi_cs2) |-> !sdo)
    else $error("sdo driven with both selects inactive");

endmodule

//--- test/tb_clock.sv
/*
 * testbench clock and reset
 * free running sck, rst_n held low for the first few cycles
 */

module tb_clock #(
  parameter int half_period  = 2,   // period 4
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release just after an edge, same phase as the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- hw/fpga_ctrl_top.sv
/*
 * instrument fpga spi control plane
 * register file on ss, pass-through to external spi ports on spi_cs2,
 * led mode select and 4094 output enable, all on the spi clock
 */

module fpga_ctrl_top #(
  parameter int                       num_spi_ports = 2,
  parameter logic [num_spi_ports-1:0] cs_polarity   = num_spi_ports'(1),  // 4094 strobe hi
  parameter int                       pattern_shift = 3
) (
  input  logic                      sck,
  input  logic                      rst_n,
  input  logic                      ss,        // register file select
  input  logic                      spi_cs2,   // pass-through select
  input  logic                      sdi,
  output logic                      sdo,
  output ctrl_pkg::led_vec_t        leds,
  input  ctrl_pkg::hw_flags_t       hw_flags,
  output logic                      oe_4094,
  output logic [num_spi_ports-1:0]  port_cs,   // port 0 is the 4094 chain
  output logic [num_spi_ports-1:0]  port_clk,
  output logic [num_spi_ports-1:0]  port_mosi,
  input  logic [num_spi_ports-1:0]  port_miso
);

  import ctrl_pkg::*;

  reg_word_t reg_led;
  reg_word_t reg_mode;
  reg_word_t reg_spi_mux;
  reg_word_t reg_4094;
  reg_word_t reg_direct;
  reg_word_t reg_status;
  logic      dout;   // only ever used through the mux

  assign oe_4094 = reg_4094[0];   // low at reset, mcu enables after supplies are up

  // readable inputs
  assign reg_status = {{(word_bits - $bits(hw_flags_t) - 1){1'b0}}, oe_4094, hw_flags};

  ////////////////////////////////////////////////////////////////////////////
  // blocks

  spi_register_set i_register_set (
    .clk         (sck),
    .rst_n       (rst_n),
    .cs          (ss),
    .din         (sdi),
    .dout        (dout),
    .reg_status  (reg_status),
    .reg_led     (reg_led),
    .reg_mode    (reg_mode),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094),
    .reg_direct  (reg_direct)
  );

  spi_port_mux #(
    .num_spi_ports (num_spi_ports),
    .cs_polarity   (cs_polarity)
  ) i_port_mux (
    .sck         (sck),
    .cs          (ss),
    .cs2         (spi_cs2),
    .mosi        (sdi),
    .dout        (dout),
    .reg_spi_mux (reg_spi_mux),
    .vec_cs      (port_cs),
    .vec_clk     (port_clk),
    .vec_mosi    (port_mosi),
    .vec_miso    (port_miso),
    .miso        (sdo)          // pin
  );

  out_mode_select #(
    .pattern_shift (pattern_shift)
  ) i_mode_select (
    .clk        (sck),
    .rst_n      (rst_n),
    .mode       (reg_mode[2:0]),
    .led_src    (reg_led[3:0]),
    .direct_src (reg_direct[3:0]),
    .leds       (leds)
  );

endmodule

//--- hw/out_mode_select.sv
/*
 * led output mode select
 * registered choice between reg_led, all on, a walking one test
 * pattern and reg_direct, unused mode codes blank the leds
 */

module out_mode_select #(
  parameter int pattern_shift = 3   // pattern steps every 2**pattern_shift clocks
) (
  input  logic               clk,
  input  logic               rst_n,
  input  ctrl_pkg::mode_t    mode,
  input  ctrl_pkg::led_vec_t led_src,
  input  ctrl_pkg::led_vec_t direct_src,
  output ctrl_pkg::led_vec_t leds
);

  import ctrl_pkg::*;

  localparam int led_bits = $bits(led_vec_t);
  localparam int pos_bits = $clog2(led_bits);
  localparam int cnt_bits = pattern_shift + pos_bits;

  logic [cnt_bits-1:0] pat_cnt;   // free running, top bits are the position
  led_vec_t            pattern;

  ////////////////////////////////////////////////////////////////////////////
  // test pattern

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pat_cnt <= '0;
    end else begin
      pat_cnt <= pat_cnt + 1'b1;
    end
  end

  assign pattern = led_vec_t'(1) << pat_cnt[cnt_bits-1 -: pos_bits];   // one hot

  ////////////////////////////////////////////////////////////////////////////
  // output register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      leds <= '0;
    end else begin
      case (mode)
        mode_led:     leds <= led_src;
        mode_all_on:  leds <= '1;
        mode_pattern: leds <= pattern;
        mode_direct:  leds <= direct_src;
        default:      leds <= '0;   // spare codes, dark
      endcase
    end
  end

endmodule

//--- hw/spi_port_mux.sv
/*
 * spi pass-through router
 * fans sck/mosi out to the port picked in reg_spi_mux while cs2 is low,
 * applies each port's select polarity and returns the matching miso
 */

module spi_port_mux #(
  parameter int                       num_spi_ports = 2,
  parameter logic [num_spi_ports-1:0] cs_polarity   = num_spi_ports'(1)  // 1 = active high
) (
  input  logic                     sck,
  input  logic                     cs,          // register file select, active low
  input  logic                     cs2,         // pass-through select, active low
  input  logic                     mosi,
  input  logic                     dout,        // register file read data
  input  ctrl_pkg::reg_word_t      reg_spi_mux,
  output logic [num_spi_ports-1:0] vec_cs,
  output logic [num_spi_ports-1:0] vec_clk,
  output logic [num_spi_ports-1:0] vec_mosi,
  input  logic [num_spi_ports-1:0] vec_miso,
  output logic                     miso
);

  logic [num_spi_ports-1:0] sel_oh;     // one hot, lowest set bit wins
  logic                     pass;       // pass-through active
  logic                     port_miso;

  assign pass = !cs2;

  // priority encode, lowest bit first
  always_comb begin
    sel_oh = '0;
    for (int i = num_spi_ports - 1; i >= 0; i--) begin
      if (reg_spi_mux[i]) begin
        sel_oh    = '0;
        sel_oh[i] = 1'b1;
      end
    end
  end

  // fan out, idle ports keep select inactive and lines low
  always_comb begin
    for (int i = 0; i < num_spi_ports; i++) begin
      vec_cs[i]   = (pass && sel_oh[i]) ? cs_polarity[i] : !cs_polarity[i];
      vec_clk[i]  = pass && sel_oh[i] && sck;
      vec_mosi[i] = pass && sel_oh[i] && mosi;
    end
  end

  assign port_miso = |(sel_oh & vec_miso);   // zero if nothing selected

  // cs2 beats cs
  always_comb begin
    if (pass) begin
      miso = port_miso;
    end else if (!cs) begin
      miso = dout;
    end else begin
      miso = 1'b0;
    end
  end

endmodule

//--- hw/spi_register_set.sv
/*
 * spi register file
 * shifts 40 bit frames in on the spi clock, returns the addressed
 * register msb first during the data phase, commits writes at frame end
 */

module spi_register_set (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cs,          // active low select
  input  logic                din,
  output logic                dout,
  input  ctrl_pkg::reg_word_t reg_status,
  output ctrl_pkg::reg_word_t reg_led,
  output ctrl_pkg::reg_word_t reg_mode,
  output ctrl_pkg::reg_word_t reg_spi_mux,
  output ctrl_pkg::reg_word_t reg_4094,
  output ctrl_pkg::reg_word_t reg_direct
);

  import ctrl_pkg::*;

  localparam int cnt_bits = $clog2(frame_bits);

  // bit count at which the last address bit arrives, and the final bit
  localparam logic [cnt_bits-1:0] cnt_addr_done = cnt_bits'(addr_bits);
  localparam logic [cnt_bits-1:0] cnt_last      = cnt_bits'(frame_bits - 1);

  logic [cnt_bits-1:0]   bit_cnt;    // doubles as the frame state
  logic [frame_bits-2:0] shift_q;    // all but the bit on the wire
  reg_addr_t             addr_q;     // latched after bit 32
  reg_word_t             out_q;      // read shifter
  reg_addr_t             rd_addr;
  reg_word_t             rd_data;
  reg_word_t             wr_data;
  logic                  wr_flag;
  logic                  frame_end;

  ////////////////////////////////////////////////////////////////////////////
  // frame decode

  // address completes with the bit being sampled now
  assign rd_addr   = {shift_q[addr_bits-2:0], din};
  assign wr_flag   = shift_q[frame_bits-2];          // bit 39, first in
  assign wr_data   = {shift_q[word_bits-2:0], din};  // valid on the last edge
  assign frame_end = !cs && (bit_cnt == cnt_last);

  // read side, value before this frame
  always_comb begin
    case (rd_addr)
      addr_led:     rd_data = reg_led;
      addr_mode:    rd_data = reg_mode;
      addr_spi_mux: rd_data = reg_spi_mux;
      addr_4094:    rd_data = reg_4094;
      addr_direct:  rd_data = reg_direct;
      addr_status:  rd_data = reg_status;
      default:      rd_data = '0;        // unknown reads as zero
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // shifting

  // input shifter
  always_ff @(posedge clk) begin
    if (!cs) begin
      shift_q <= {shift_q[frame_bits-3:0], din};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
      addr_q  <= '0;
      out_q   <= '0;
    end else if (cs) begin
      bit_cnt <= '0;    // deselect drops a partial frame
    end else begin
      if (bit_cnt == cnt_last) begin
        bit_cnt <= '0;  // back to back frames allowed
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end

      if (bit_cnt == cnt_addr_done) begin
        addr_q <= rd_addr;
        out_q  <= rd_data;    // bit 31 shows right away
      end else begin
        out_q  <= {out_q[word_bits-2:0], 1'b0};
      end
    end
  end

  assign dout = out_q[word_bits-1];   // mux gates it with ss

  ////////////////////////////////////////////////////////////////////////////
  // write commit

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_led     <= '0;
      reg_mode    <= '0;    // mode_led
      reg_spi_mux <= '0;
      reg_4094    <= '0;    // chain disabled at start-up
      reg_direct  <= '0;
    end else if (frame_end && wr_flag) begin
      case (addr_q)
        addr_led:     reg_led     <= wr_data;
        addr_mode:    reg_mode    <= wr_data;
        addr_spi_mux: reg_spi_mux <= wr_data;
        addr_4094:    reg_4094    <= wr_data;
        addr_direct:  reg_direct  <= wr_data;
        default: ;    // status and unknown ignored
      endcase
    end
  end

endmodule

//--- hw/ctrl_pkg.sv
/*
 * control plane definitions
 * register address map, spi frame widths, output mode codes
 * and the vector types shared by the register file, mux and top
 */

package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int word_bits  = 32;   // register payload
  localparam int addr_bits  = 7;
  localparam int frame_bits = 1 + addr_bits + word_bits;   // wr flag + addr + data = 40

  typedef logic [word_bits-1:0] reg_word_t;
  typedef logic [addr_bits-1:0] reg_addr_t;

  typedef logic [3:0] led_vec_t;    // front panel leds
  typedef logic [2:0] hw_flags_t;   // HW0..HW2 inputs

  ////////////////////////////////////////////////////////////////////////////
  // register map

  localparam reg_addr_t addr_led     = 7'd0;
  localparam reg_addr_t addr_mode    = 7'd1;
  localparam reg_addr_t addr_spi_mux = 7'd2;
  localparam reg_addr_t addr_4094    = 7'd3;   // bit 0 is the chain oe
  localparam reg_addr_t addr_direct  = 7'd4;
  localparam reg_addr_t addr_status  = 7'd5;   // read only

  ////////////////////////////////////////////////////////////////////////////
  // output modes, unlisted codes blank the leds

  typedef logic [2:0] mode_t;

  localparam mode_t mode_led     = 3'd0;   // follow reg_led
  localparam mode_t mode_all_on  = 3'd1;
  localparam mode_t mode_pattern = 3'd2;   // walking one
  localparam mode_t mode_direct  = 3'd3;   // follow reg_direct

endpackage
